// ==== design/pic_types_pkg.sv ====
package pic_types_pkg;

   //////////////////////////////////////////////////
   // Field widths
   //////////////////////////////////////////////////

   localparam int PRIO_BITS = 4;                 // Priority field of a source
   localparam int ID_BITS   = 8;                 // Claim ID, covers up to 256 sources

   // Priority level, larger is more urgent in normal order
   typedef logic [PRIO_BITS-1:0] prio_t;

   // Source number as reported in claimid
   typedef logic [ID_BITS-1:0] src_id_t;

   //////////////////////////////////////////////////
   // Register port
   //////////////////////////////////////////////////

   typedef logic [31:0] bus_addr_t;              // Byte address
   typedef logic [31:0] bus_data_t;              // One register word

   // Most urgent level in normal order, also the wake-up level
   localparam prio_t PRIO_MAX = prio_t'(15);

endpackage

// ==== design/pic_map_pkg.sv ====
package pic_map_pkg;

   //////////////////////////////////////////////////
   // Register map
   //////////////////////////////////////////////////

   // Start of the PIC register space
   localparam pic_types_pkg::bus_addr_t PIC_BASE_ADDR = 32'hF00C_0000;

   // Block offsets from the base, one 4 KB block each
   localparam pic_types_pkg::bus_addr_t PRIO_OFS      = 32'h0000_0000;  // Per-source priority
   localparam pic_types_pkg::bus_addr_t PEND_OFS      = 32'h0000_1000;  // Pending, 32 per word
   localparam pic_types_pkg::bus_addr_t ENABLE_OFS    = 32'h0000_2000;  // Per-source enable
   localparam pic_types_pkg::bus_addr_t CONFIG_OFS    = 32'h0000_3000;  // Priority order bit
   localparam pic_types_pkg::bus_addr_t GW_CONFIG_OFS = 32'h0000_4000;  // Polarity and type
   localparam pic_types_pkg::bus_addr_t GW_CLEAR_OFS  = 32'h0000_5000;  // Edge latch clear

   // Registers sit on word boundaries, so the source index starts at bit 2
   localparam int IDX_LSB = 2;

endpackage

// ==== design/pic_reg_ctrl.sv ====
`timescale 1ns/1ps

module pic_reg_ctrl #(
   parameter int NUM_INT = 32
) (
   input  logic                               clk,
   input  logic                               rst_n,
   input  pic_types_pkg::bus_addr_t           picm_addr,
   input  pic_types_pkg::bus_data_t           picm_wr_data,
   input  logic                               picm_wren,
   input  logic                               picm_rden,
   input  logic [NUM_INT-1:0]                 gw_req,
   output pic_types_pkg::bus_data_t           picm_rd_data,
   output pic_types_pkg::prio_t [NUM_INT-1:0] int_priority,
   output logic [NUM_INT-1:0]                 int_enable,
   output logic [NUM_INT-1:0]                 gw_polarity,
   output logic [NUM_INT-1:0]                 gw_edge,
   output logic [NUM_INT-1:0]                 gw_clear,
   output logic                               reverse_order
);

   import pic_types_pkg::*;
   import pic_map_pkg::*;

   localparam int IDX_BITS  = $clog2(NUM_INT);
   localparam int BLK_LSB   = IDX_LSB + IDX_BITS;   // Lowest bit of the block match
   localparam int PEND_GRPS = (NUM_INT + 31) / 32;
   localparam int PEND_W    = PEND_GRPS * 32;

   bus_addr_t           addr_q;
   bus_data_t           wr_data_q;
   logic                wren_q;
   logic                rden_q;
   logic [IDX_BITS-1:0] idx_q;
   logic [NUM_INT-1:0]  src_sel;                    // One-hot source select, never bit 0
   logic                prio_hit;
   logic                pend_hit;
   logic                en_hit;
   logic                cfg_hit;
   logic                gw_cfg_hit;
   logic                gw_clr_hit;
   logic [PEND_W-1:0]   pend_ext;
   bus_data_t           pend_word;
   prio_t               prio_rd;
   logic                en_rd;
   logic [1:0]          gw_cfg_rd;

   // True when the captured address falls in the block at ofs
   function automatic logic blk_match(input bus_addr_t addr, input bus_addr_t ofs);
      bus_addr_t blk_addr;
      blk_addr = PIC_BASE_ADDR + ofs;
      return (addr >> BLK_LSB) == (blk_addr >> BLK_LSB);
   endfunction

   //////////////////////////////////////////////////
   // Request capture
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wren_q <= 1'b0;
         rden_q <= 1'b0;
      end else begin
         wren_q <= picm_wren;
         rden_q <= picm_rden;
      end
   end

   always_ff @(posedge clk) begin
      if (picm_wren || picm_rden) begin
         addr_q <= picm_addr;
      end
      if (picm_wren) begin
         wr_data_q <= picm_wr_data;
      end
   end

   // Block and index decode
   assign idx_q      = addr_q[BLK_LSB-1:IDX_LSB];
   assign prio_hit   = blk_match(addr_q, PRIO_OFS);
   assign pend_hit   = blk_match(addr_q, PEND_OFS);
   assign en_hit     = blk_match(addr_q, ENABLE_OFS);
   assign gw_cfg_hit = blk_match(addr_q, GW_CONFIG_OFS);
   assign gw_clr_hit = blk_match(addr_q, GW_CLEAR_OFS);
   assign cfg_hit    = blk_match(addr_q, CONFIG_OFS) && (idx_q == '0);

   always_comb begin
      src_sel = '0;
      for (int i = 1; i < NUM_INT; i++) begin   // Index 0 and out-of-range indices hit nothing
         src_sel[i] = (idx_q == i);
      end
   end

   //////////////////////////////////////////////////
   // Configuration registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         int_priority  <= '0;
         int_enable    <= '0;
         gw_polarity   <= '0;
         gw_edge       <= '0;
         reverse_order <= 1'b0;
      end else if (wren_q) begin
         for (int i = 0; i < NUM_INT; i++) begin
            if (src_sel[i] && prio_hit) begin
               int_priority[i] <= prio_t'(wr_data_q[PRIO_BITS-1:0]);
            end
            if (src_sel[i] && en_hit) begin
               int_enable[i] <= wr_data_q[0];
            end
            if (src_sel[i] && gw_cfg_hit) begin
               gw_polarity[i] <= wr_data_q[0];   // 1 inverts the request
               gw_edge[i]     <= wr_data_q[1];   // 1 selects edge mode
            end
         end
         if (cfg_hit) begin
            reverse_order <= wr_data_q[0];
         end
      end
   end

   // Clear pulse lines up with the register update edge
   assign gw_clear = src_sel & {NUM_INT{wren_q & gw_clr_hit}};

   //////////////////////////////////////////////////
   // Read data
   //////////////////////////////////////////////////

   assign pend_ext = PEND_W'(gw_req);

   always_comb begin
      pend_word = '0;
      prio_rd   = '0;
      en_rd     = 1'b0;
      gw_cfg_rd = '0;
      for (int g = 0; g < PEND_GRPS; g++) begin
         if (idx_q == g) begin
            pend_word = pend_ext[g*32 +: 32];
         end
      end
      for (int i = 0; i < NUM_INT; i++) begin
         if (src_sel[i]) begin
            prio_rd   = int_priority[i];
            en_rd     = int_enable[i];
            gw_cfg_rd = {gw_edge[i], gw_polarity[i]};
         end
      end
   end

   // Only the selected field reaches the bus, zero otherwise
   always_comb begin
      picm_rd_data = '0;
      if (rden_q) begin
         if (pend_hit) begin
            picm_rd_data |= pend_word;
         end
         if (prio_hit) begin
            picm_rd_data |= bus_data_t'(prio_rd);
         end
         if (en_hit) begin
            picm_rd_data |= bus_data_t'(en_rd);
         end
         if (gw_cfg_hit) begin
            picm_rd_data |= bus_data_t'(gw_cfg_rd);
         end
         if (cfg_hit) begin
            picm_rd_data |= bus_data_t'(reverse_order);
         end
      end
   end

endmodule

// ==== design/pic_gateway_bank.sv ====
`timescale 1ns/1ps

module pic_gateway_bank #(
   parameter int NUM_INT = 32
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic [NUM_INT-1:0] extintsrc_req,
   input  logic [NUM_INT-1:0] gw_polarity,
   input  logic [NUM_INT-1:0] gw_edge,
   input  logic [NUM_INT-1:0] gw_clear,
   output logic [NUM_INT-1:0] gw_req
);

   // Source 0 is reserved, so only 1 and up get hardware
   logic [NUM_INT-1:1] sync_meta;      // First synchroniser stage
   logic [NUM_INT-1:1] sync_req;       // Second stage, safe to use
   logic [NUM_INT-1:1] req_lvl;        // Request after polarity
   logic [NUM_INT-1:1] edge_pend;      // Edge-pending latch per source

   //////////////////////////////////////////////////
   // Two-flop synchroniser and edge latch
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_meta <= '0;
         sync_req  <= '0;
         edge_pend <= '0;
      end else begin
         sync_meta <= extintsrc_req[NUM_INT-1:1];
         sync_req  <= sync_meta;
         // Set while the request is active, drop on a clear with the request idle
         edge_pend <= req_lvl | (edge_pend & ~gw_clear[NUM_INT-1:1]);
      end
   end

   assign req_lvl = sync_req ^ gw_polarity[NUM_INT-1:1];

   // Level mode passes the request, edge mode adds the latch
   assign gw_req = {req_lvl | (edge_pend & gw_edge[NUM_INT-1:1]), 1'b0};

endmodule

// ==== design/pic_priority_tree.sv ====
`timescale 1ns/1ps

module pic_priority_tree #(
   parameter int NUM_INT = 32
) (
   input  logic [NUM_INT-1:0]                 gw_req,
   input  logic [NUM_INT-1:0]                 int_enable,
   input  pic_types_pkg::prio_t [NUM_INT-1:0] int_priority,
   input  logic                               reverse_order,
   output pic_types_pkg::src_id_t             best_id,
   output pic_types_pkg::prio_t               best_prio
);

   import pic_types_pkg::*;

   localparam int LEVELS = $clog2(NUM_INT);

   // Level 0 holds the leaves, level LEVELS the single winner
   prio_t   lvl_prio [LEVELS+1][NUM_INT];
   src_id_t lvl_id   [LEVELS+1][NUM_INT];

   // Number of live entries on a level
   function automatic int lvl_width(input int l);
      return (NUM_INT + (1 << l) - 1) >> l;
   endfunction

   // Pairwise compare-select, a keeps the tie
   function automatic logic [ID_BITS+PRIO_BITS-1:0] cmp_sel(
      input src_id_t a_id,
      input prio_t   a_prio,
      input src_id_t b_id,
      input prio_t   b_prio
   );
      if (a_prio < b_prio) begin
         return {b_id, b_prio};
      end
      return {a_id, a_prio};
   endfunction

   //////////////////////////////////////////////////
   // Leaves: masked and oriented priorities
   //////////////////////////////////////////////////

   for (genvar m = 0; m < NUM_INT; m++) begin : g_leaf
      assign lvl_prio[0][m] = (gw_req[m] && int_enable[m]) ?
                              (reverse_order ? ~int_priority[m] : int_priority[m]) : '0;
      assign lvl_id[0][m]   = src_id_t'(m);
   end

   //////////////////////////////////////////////////
   // Reduction levels
   //////////////////////////////////////////////////

   for (genvar l = 0; l < LEVELS; l++) begin : g_level
      for (genvar m = 0; m < NUM_INT; m++) begin : g_node
         if (2*m + 1 < lvl_width(l)) begin : g_pair
            assign {lvl_id[l+1][m], lvl_prio[l+1][m]} =
               cmp_sel(lvl_id[l][2*m], lvl_prio[l][2*m],
                       lvl_id[l][2*m+1], lvl_prio[l][2*m+1]);
         end else if (2*m < lvl_width(l)) begin : g_odd
            // Last entry of an odd level meets a zero pad
            assign {lvl_id[l+1][m], lvl_prio[l+1][m]} =
               cmp_sel(lvl_id[l][2*m], lvl_prio[l][2*m], '0, '0);
         end else begin : g_idle
            assign lvl_id[l+1][m]   = '0;
            assign lvl_prio[l+1][m] = '0;
         end
      end
   end

   assign best_id   = lvl_id[LEVELS][0];
   assign best_prio = lvl_prio[LEVELS][0];   // Still in internal order

endmodule

// ==== design/pic_claim_stage.sv ====
`timescale 1ns/1ps

module pic_claim_stage #(
   parameter int NUM_INT = 32
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  pic_types_pkg::src_id_t  best_id,
   input  pic_types_pkg::prio_t    best_prio,
   input  logic                    reverse_order,
   input  pic_types_pkg::prio_t    meipt,
   input  pic_types_pkg::prio_t    meicurpl,
   output pic_types_pkg::src_id_t  claimid,
   output pic_types_pkg::prio_t    pl,
   output logic                    mexintpend,
   output logic                    mhwakeup
);

   import pic_types_pkg::*;

   localparam int IDX_BITS = $clog2(NUM_INT);

   prio_t               thr_int;     // Threshold in internal order
   prio_t               cur_int;     // Current level in internal order
   prio_t               pl_nxt;
   logic                pend_nxt;
   logic                wake_nxt;
   logic [IDX_BITS-1:0] id_q;        // Upper ID bits are always zero

   assign thr_int = reverse_order ? ~meipt : meipt;
   assign cur_int = reverse_order ? ~meicurpl : meicurpl;

   // Winner must beat both threshold and current level
   assign pend_nxt = (best_prio > thr_int) && (best_prio > cur_int);

   assign pl_nxt   = reverse_order ? ~best_prio : best_prio;   // Back to external order
   assign wake_nxt = (best_prio == PRIO_MAX);   // 15 normal, 0 reversed

   //////////////////////////////////////////////////
   // Claim registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_q       <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         id_q       <= best_id[IDX_BITS-1:0];
         pl         <= pl_nxt;
         mexintpend <= pend_nxt;
         mhwakeup   <= wake_nxt;
      end
   end

   assign claimid = src_id_t'(id_q);

endmodule

// ==== design/pic_top.sv ====
`timescale 1ns/1ps

module pic_top #(
   parameter int NUM_INT = 32
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [NUM_INT-1:0]       extintsrc_req,
   input  pic_types_pkg::bus_addr_t picm_addr,
   input  pic_types_pkg::bus_data_t picm_wr_data,
   input  logic                     picm_wren,
   input  logic                     picm_rden,
   input  pic_types_pkg::prio_t     meipt,
   input  pic_types_pkg::prio_t     meicurpl,
   output pic_types_pkg::bus_data_t picm_rd_data,
   output pic_types_pkg::src_id_t   claimid,
   output pic_types_pkg::prio_t     pl,
   output logic                     mexintpend,
   output logic                     mhwakeup
);

   import pic_types_pkg::*;

   logic [NUM_INT-1:0]         gw_req;
   logic [NUM_INT-1:0]         gw_polarity;
   logic [NUM_INT-1:0]         gw_edge;
   logic [NUM_INT-1:0]         gw_clear;
   logic [NUM_INT-1:0]         int_enable;
   prio_t [NUM_INT-1:0]        int_priority;
   logic                       reverse_order;
   src_id_t                    best_id;
   prio_t                      best_prio;

   //////////////////////////////////////////////////
   // Register block
   //////////////////////////////////////////////////

   pic_reg_ctrl #(
      .NUM_INT (NUM_INT)
   ) reg_ctrl_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .picm_addr     (picm_addr),
      .picm_wr_data  (picm_wr_data),
      .picm_wren     (picm_wren),
      .picm_rden     (picm_rden),
      .gw_req        (gw_req),         // Pending readback
      .picm_rd_data  (picm_rd_data),
      .int_priority  (int_priority),
      .int_enable    (int_enable),
      .gw_polarity   (gw_polarity),
      .gw_edge       (gw_edge),
      .gw_clear      (gw_clear),
      .reverse_order (reverse_order)
   );

   //////////////////////////////////////////////////
   // Interrupt datapath
   //////////////////////////////////////////////////

   pic_gateway_bank #(
      .NUM_INT (NUM_INT)
   ) gateway_bank_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .extintsrc_req (extintsrc_req),
      .gw_polarity   (gw_polarity),
      .gw_edge       (gw_edge),
      .gw_clear      (gw_clear),
      .gw_req        (gw_req)
   );

   pic_priority_tree #(
      .NUM_INT (NUM_INT)
   ) priority_tree_i (
      .gw_req        (gw_req),
      .int_enable    (int_enable),
      .int_priority  (int_priority),
      .reverse_order (reverse_order),
      .best_id       (best_id),
      .best_prio     (best_prio)
   );

   pic_claim_stage #(
      .NUM_INT (NUM_INT)
   ) claim_stage_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .best_id       (best_id),
      .best_prio     (best_prio),
      .reverse_order (reverse_order),
      .meipt         (meipt),
      .meicurpl      (meicurpl),
      .claimid       (claimid),
      .pl            (pl),
      .mexintpend    (mexintpend),
      .mhwakeup      (mhwakeup)
   );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter real PERIOD_NS = 4.0
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0) clk = ~clk;   // 50 % duty
      end
   end

endmodule

// ==== test/pic_assert.sv ====
`timescale 1ns/1ps

module pic_assert (
   input logic                     clk,
   input logic                     rst_n,
   input pic_types_pkg::src_id_t   claimid,
   input pic_types_pkg::prio_t     pl,
   input logic                     mexintpend,
   input logic                     mhwakeup,
   input logic                     reverse_order,
   input pic_types_pkg::bus_addr_t picm_addr,
   input logic                     picm_rden,
   input pic_types_pkg::bus_data_t picm_rd_data
);

   import pic_map_pkg::*;

   int unsigned error_count = 0;   // Failed assertions so far, watched by the testbench top
   logic        prio_read;

   assign prio_read = picm_rden && ((picm_addr >> 12) == ((PIC_BASE_ADDR + PRIO_OFS) >> 12));

   // A pending interrupt always names a real source
   pend_has_id : assert property (@(posedge clk) disable iff (!rst_n)
      mexintpend |-> (claimid != '0))
      else begin
         error_count++;
         $error("mexintpend set with claimid 0");
      end

   // Wake-up level depends on the order in force when the claim was taken
   wake_rule : assert property (@(posedge clk) disable iff (!rst_n)
      1'b1 |=> (mhwakeup == ($past(reverse_order) ? (pl == 4'd0) : (pl == 4'd15))))
      else begin
         error_count++;
         $error("mhwakeup does not follow pl");
      end

   idle_read_zero : assert property (@(posedge clk) disable iff (!rst_n)
      !picm_rden |=> (picm_rd_data == '0))
      else begin
         error_count++;
         $error("read data not zero after an idle cycle");
      end

   prio_read_width : assert property (@(posedge clk) disable iff (!rst_n)
      prio_read |=> (picm_rd_data[31:4] == '0))
      else begin
         error_count++;
         $error("priority read has upper bits set");
      end

endmodule

bind pic_top pic_assert assert_i (
   .clk           (clk),
   .rst_n         (rst_n),
   .claimid       (claimid),
   .pl            (pl),
   .mexintpend    (mexintpend),
   .mhwakeup      (mhwakeup),
   .reverse_order (reverse_order),
   .picm_addr     (picm_addr),
   .picm_rden     (picm_rden),
   .picm_rd_data  (picm_rd_data)
);

// ==== test/pic_tb.sv ====
`timescale 1ns/1ps

module pic_tb;

   import pic_types_pkg::*;
   import pic_map_pkg::*;

   localparam int NUM_INT = 32;
   // Budget per test group: reset, readback, level, arbitration, threshold, edge, reverse, margin
   localparam int WATCHDOG_CYCLES = 8 + 500 + 60 + 700 + 120 + 80 + 400 + 1000;

   logic               clk;
   logic               rst_n;
   logic [NUM_INT-1:0] ext_req;
   bus_addr_t          picm_addr;
   bus_data_t          picm_wr_data;
   logic               picm_wren;
   logic               picm_rden;
   prio_t              meipt;
   prio_t              meicurpl;
   bus_data_t          picm_rd_data;
   src_id_t            claimid;
   prio_t              pl;
   logic               mexintpend;
   logic               mhwakeup;

   // Reference model of the register state and request levels
   prio_t              ref_prio [NUM_INT];
   logic [NUM_INT-1:0] ref_en;
   logic [NUM_INT-1:0] ref_pol;
   logic [NUM_INT-1:0] ref_edge;
   logic [NUM_INT-1:0] ref_latch;
   logic [NUM_INT-1:0] ref_req;
   logic               ref_rev;
   integer             seed;

   tb_clock_gen #(.PERIOD_NS(4.0)) clock_i (.clk(clk));

   pic_top #(
      .NUM_INT (NUM_INT)
   ) dut_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .extintsrc_req (ext_req),
      .picm_addr     (picm_addr),
      .picm_wr_data  (picm_wr_data),
      .picm_wren     (picm_wren),
      .picm_rden     (picm_rden),
      .meipt         (meipt),
      .meicurpl      (meicurpl),
      .picm_rd_data  (picm_rd_data),
      .claimid       (claimid),
      .pl            (pl),
      .mexintpend    (mexintpend),
      .mhwakeup      (mhwakeup)
   );

   //////////////////////////////////////////////////
   // Reference rules
   //////////////////////////////////////////////////

   function automatic logic [NUM_INT-1:0] expected_gw();
      logic [NUM_INT-1:0] lvl;
      lvl = ref_req ^ ref_pol;
      return (lvl | (ref_edge & ref_latch)) & ~NUM_INT'(1);   // Source 0 never requests
   endfunction

   function automatic bus_data_t expected_read(input bus_addr_t ofs, input int idx);
      if (ofs == PEND_OFS) return (idx == 0) ? bus_data_t'(expected_gw()) : '0;
      if (ofs == CONFIG_OFS) return (idx == 0) ? bus_data_t'(ref_rev) : '0;
      if (idx == 0) return '0;
      if (ofs == PRIO_OFS) return bus_data_t'(ref_prio[idx]);
      if (ofs == ENABLE_OFS) return bus_data_t'(ref_en[idx]);
      if (ofs == GW_CONFIG_OFS) return bus_data_t'({ref_edge[idx], ref_pol[idx]});
      return '0;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
         $display("Simulation failed");
         $fatal(1, "check %s failed", name);
      end
   endtask

   task automatic check_outputs(input string name);
      logic [NUM_INT-1:0] gw;
      prio_t              eff;
      prio_t              best_eff;
      prio_t              thr;
      prio_t              cur;
      prio_t              exp_pl;
      src_id_t            best;
      gw       = expected_gw();
      best     = '0;
      best_eff = '0;
      thr      = ref_rev ? ~meipt : meipt;
      cur      = ref_rev ? ~meicurpl : meicurpl;
      for (int i = 1; i < NUM_INT; i++) begin
         if (gw[i] && ref_en[i]) begin
            eff = ref_rev ? ~ref_prio[i] : ref_prio[i];
            if (eff > best_eff) begin   // Strict compare keeps the lower ID on ties
               best_eff = eff;
               best     = src_id_t'(i);
            end
         end
      end
      exp_pl = ref_rev ? ~best_eff : best_eff;
      check_value({name, " claimid"}, best, claimid);
      check_value({name, " pl"}, exp_pl, pl);
      check_value({name, " mexintpend"}, (best_eff > thr) && (best_eff > cur), mexintpend);
      check_value({name, " mhwakeup"},
                  ref_rev ? (exp_pl == 4'd0) : (exp_pl == 4'd15), mhwakeup);
   endtask

   //////////////////////////////////////////////////
   // Bus and pin drivers
   //////////////////////////////////////////////////

   task automatic reg_write(input bus_addr_t ofs, input int idx, input bus_data_t data);
      logic [NUM_INT-1:0] lvl;
      @(posedge clk);
      picm_addr    <= PIC_BASE_ADDR + ofs + bus_addr_t'(idx << IDX_LSB);
      picm_wr_data <= data;
      picm_wren    <= 1'b1;
      @(posedge clk);
      picm_wren    <= 1'b0;
      lvl = ref_req ^ ref_pol;
      if (idx > 0 && idx < NUM_INT) begin
         if (ofs == PRIO_OFS) ref_prio[idx] = data[3:0];
         if (ofs == ENABLE_OFS) ref_en[idx] = data[0];
         if (ofs == GW_CONFIG_OFS) begin
            ref_pol[idx]  = data[0];
            ref_edge[idx] = data[1];
         end
         if (ofs == GW_CLEAR_OFS) ref_latch[idx] = lvl[idx];   // Active request re-arms it
      end
      if (ofs == CONFIG_OFS && idx == 0) ref_rev = data[0];
      ref_latch |= ref_req ^ ref_pol;
   endtask

   task automatic reg_read(input bus_addr_t ofs, input int idx, output bus_data_t data);
      @(posedge clk);
      picm_addr <= PIC_BASE_ADDR + ofs + bus_addr_t'(idx << IDX_LSB);
      picm_rden <= 1'b1;
      @(posedge clk);
      picm_rden <= 1'b0;
      @(negedge clk);
      data = picm_rd_data;
   endtask

   task automatic drive_req(input logic [NUM_INT-1:0] req);
      @(posedge clk);
      ext_req <= req;
      ref_req = req;
      ref_latch |= ref_req ^ ref_pol;
   endtask

   task automatic drive_levels(input prio_t thr, input prio_t cur);
      @(posedge clk);
      meipt    <= thr;
      meicurpl <= cur;
   endtask

   // Three edges covers synchroniser plus claim register
   task automatic settle();
      repeat (3) @(posedge clk);
      @(negedge clk);
   endtask

   //////////////////////////////////////////////////
   // Test groups
   //////////////////////////////////////////////////

   task automatic readback_checks();
      bus_addr_t blocks [4];
      bus_addr_t ofs;
      bus_data_t data;
      bus_data_t rd;
      int        idx;
      blocks = '{PRIO_OFS, ENABLE_OFS, GW_CONFIG_OFS, CONFIG_OFS};
      for (int k = 0; k < 40; k++) begin
         ofs  = blocks[$unsigned($random(seed)) % 4];
         idx  = (ofs == CONFIG_OFS) ? 0 : 1 + ($unsigned($random(seed)) % (NUM_INT - 1));
         data = $random(seed);
         reg_write(ofs, idx, data);
         reg_read(ofs, idx, rd);
         check_value("readback", expected_read(ofs, idx), rd);
      end
      for (int b = 0; b < 3; b++) begin
         reg_write(blocks[b], 0, 32'hffff_ffff);
         reg_read(blocks[b], 0, rd);
         check_value("index 0 readback", 32'h0, rd);
      end
      // Back to level mode, normal polarity and order, with latches cleared
      for (int i = 1; i < NUM_INT; i++) begin
         reg_write(GW_CONFIG_OFS, i, 32'h0);
         reg_write(GW_CLEAR_OFS, i, 32'h0);
      end
      reg_write(CONFIG_OFS, 0, 32'h0);
   endtask

   task automatic random_trial(input string name);
      int idx;
      for (int s = 0; s < 6; s++) begin
         idx = 1 + ($unsigned($random(seed)) % (NUM_INT - 1));
         reg_write(PRIO_OFS, idx, $random(seed));
         reg_write(ENABLE_OFS, idx, ($unsigned($random(seed)) % 4) != 0);
      end
      drive_req($random(seed));
      settle();
      check_outputs(name);
   endtask

   task automatic level_checks();
      bus_data_t rd;
      reg_write(PRIO_OFS, 3, 32'd5);
      reg_write(ENABLE_OFS, 3, 32'd1);
      reg_write(PRIO_OFS, 12, 32'd11);
      reg_write(ENABLE_OFS, 12, 32'd1);
      drive_levels(4'd2, 4'd0);
      drive_req(32'h0000_1008);
      settle();
      check_outputs("level");
      reg_read(PEND_OFS, 0, rd);
      check_value("level pending", expected_gw(), rd);
   endtask

   task automatic threshold_checks();
      drive_req(32'h0);
      for (int i = 1; i < NUM_INT; i++) begin
         reg_write(ENABLE_OFS, i, i == 9);
      end
      reg_write(PRIO_OFS, 9, 32'd9);
      drive_req(32'h0000_0200);
      drive_levels(4'd8, 4'd0);
      settle();
      check_outputs("threshold below");
      drive_levels(4'd9, 4'd0);
      settle();
      check_outputs("threshold equal");
      drive_levels(4'd0, 4'd9);
      settle();
      check_outputs("current level equal");
      reg_write(PRIO_OFS, 9, 32'd15);
      settle();
      check_outputs("wake-up");
      drive_levels(4'd0, 4'd0);
   endtask

   task automatic edge_polarity_checks();
      bus_data_t rd;
      drive_req(32'h0);
      reg_write(GW_CONFIG_OFS, 5, 32'd2);
      reg_write(PRIO_OFS, 5, 32'd6);
      reg_write(ENABLE_OFS, 5, 32'd1);
      reg_write(GW_CLEAR_OFS, 5, 32'd0);
      settle();
      check_outputs("edge idle");
      drive_req(32'h0000_0020);   // One-cycle pulse
      drive_req(32'h0);
      settle();
      check_outputs("edge held");
      reg_read(PEND_OFS, 0, rd);
      check_value("edge pending", expected_gw(), rd);
      reg_write(GW_CLEAR_OFS, 5, 32'd0);
      settle();
      check_outputs("edge cleared");
      reg_write(GW_CONFIG_OFS, 7, 32'd1);
      reg_write(PRIO_OFS, 7, 32'd3);
      reg_write(ENABLE_OFS, 7, 32'd1);
      settle();
      check_outputs("polarity input low");
      drive_req(32'h0000_0080);
      settle();
      check_outputs("polarity input high");
   endtask

   task automatic reverse_checks();
      reg_write(CONFIG_OFS, 0, 32'd1);
      drive_levels(4'd12, 4'd14);   // Reverse order, so these are low barriers
      for (int t = 0; t < 10; t++) begin
         random_trial("reverse order");
      end
      // Priority 0 is the most urgent level here
      reg_write(ENABLE_OFS, 9, 32'd1);
      reg_write(PRIO_OFS, 9, 32'd0);
      drive_req(32'h0000_0200);
      settle();
      check_outputs("reverse wake-up");
      drive_levels(4'd0, 4'd14);
      settle();
      check_outputs("reverse threshold equal");
   endtask

   //////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////

   initial begin
      seed         = 32'hba5fd0c6;
      rst_n        = 1'b0;
      ext_req      = '0;
      picm_addr    = '0;
      picm_wr_data = '0;
      picm_wren    = 1'b0;
      picm_rden    = 1'b0;
      meipt        = '0;
      meicurpl     = '0;
      ref_en       = '0;
      ref_pol      = '0;
      ref_edge     = '0;
      ref_latch    = '0;
      ref_req      = '0;
      ref_rev      = 1'b0;
      for (int i = 0; i < NUM_INT; i++) begin
         ref_prio[i] = '0;
      end
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      readback_checks();
      level_checks();
      for (int t = 0; t < 12; t++) begin
         random_trial("arbitration");
      end
      threshold_checks();
      edge_polarity_checks();
      reverse_checks();
      if (dut_i.assert_i.error_count != 0) begin
         $display("Simulation failed");
         $fatal(1, "assertion failed");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

   // Any failed assertion in the bound checker ends the run
   always @(negedge clk) begin
      if (dut_i.assert_i.error_count != 0) begin
         $display("An assertion in the bound checker failed");
         $display("Simulation failed");
         $fatal(1, "assertion failed");
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired before the tests completed");
      $display("Simulation failed");
      $fatal(1, "timeout");
   end

endmodule

// ==== project.f ====
design/pic_types_pkg.sv
design/pic_map_pkg.sv
design/pic_reg_ctrl.sv
design/pic_gateway_bank.sv
design/pic_priority_tree.sv
design/pic_claim_stage.sv
design/pic_top.sv
test/tb_clock_gen.sv
test/pic_assert.sv
test/pic_tb.sv

// ==== Bender.yml ====
package:
  name: pic

sources:
  - files:
      - design/pic_types_pkg.sv
      - design/pic_map_pkg.sv
      - design/pic_reg_ctrl.sv
      - design/pic_gateway_bank.sv
      - design/pic_priority_tree.sv
      - design/pic_claim_stage.sv
      - design/pic_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/pic_assert.sv
      - test/pic_tb.sv
